//--- rtl/mem_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// Bus geometry
`define MEM_XLEN      32
`define MEM_STRB      (`MEM_XLEN / 8)

// Storage geometry
`define MEM_BYTES     1024
`define MEM_ADDR_BITS $clog2(`MEM_BYTES)

// Byte parts per bus word
`define MEM_PARTS     4

`endif

//--- rtl/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // Controller states
    typedef enum logic [2:0] {
        IDLE         = 3'd0,
        FETCH        = 3'd1,
        PROCESS      = 3'd2,
        WRITE_BACK   = 3'd3,
        RESPOND      = 3'd4,
        RESPOND_WAIT = 3'd5
    } mem_state_t;

    // Bus size codes as log2 of bytes per access
    typedef enum logic [2:0] {
        SIZE_BYTE = 3'd0,
        SIZE_HALF = 3'd1,
        SIZE_WORD = 3'd2   // Anything above is unsupported
    } access_size_t;

endpackage

`default_nettype wire

//--- rtl/mem_seq_if.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_settings.svh"

// Word access link between controller and part sequencer
interface mem_seq_if;
    logic                      start;
    logic                      write;      // High for write back
    logic [`MEM_ADDR_BITS-1:0] word_addr;  // First byte of the word
    logic [`MEM_XLEN-1:0]      wdata;
    logic                      done;
    logic [`MEM_XLEN-1:0]      rdata;      // Valid while done after a fetch

    modport ctrl (
        output start, write, word_addr, wdata,
        input  done, rdata
    );

    modport seq (
        input  start, write, word_addr, wdata,
        output done, rdata
    );
endinterface

`default_nettype wire

//--- rtl/block_ram.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_settings.svh"

module block_ram #(
    parameter int DEPTH = `MEM_BYTES
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    input  logic [7:0]               wdata,
    output logic [7:0]               rdata
);

    logic [7:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];  // One cycle read latency
    end

endmodule

`default_nettype wire

//--- rtl/mem_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_settings.svh"

module mem_sequencer (
    input  logic                      clk,
    input  logic                      reset,
    mem_seq_if.seq                    seq,
    output logic                      ram_we,
    output logic [`MEM_ADDR_BITS-1:0] ram_waddr,
    output logic [`MEM_ADDR_BITS-1:0] ram_raddr,
    output logic [7:0]                ram_wdata,
    input  logic [7:0]                ram_rdata
);

    localparam int AW       = `MEM_ADDR_BITS;
    localparam int XW       = `MEM_XLEN;
    localparam int CNT_BITS = $clog2(`MEM_PARTS);
    localparam logic [CNT_BITS-1:0] LAST_PART = CNT_BITS'(`MEM_PARTS - 1);

    // Per-part read steps
    typedef enum logic [1:0] {
        RD_ADDR,
        RD_WAIT,
        RD_CAPTURE
    } rd_phase_t;

    rd_phase_t           phase;
    logic [CNT_BITS-1:0] part;
    logic [AW-1:0]       part_addr;
    logic                part_last;
    logic                active;

    assign active    = seq.start && !seq.done;
    assign part_addr = seq.word_addr + AW'(part);  // Wraps at the top of memory
    assign part_last = (part == LAST_PART);

    ////////////////////////////////////////////////////////////////////////////
    // Part counter and handshake
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            seq.done <= 1'b0;
            part     <= '0;
            phase    <= RD_ADDR;
            ram_we   <= 1'b0;
        end else if (active) begin
            if (seq.write) begin
                ram_we   <= 1'b1;  // One byte per cycle
                part     <= part + 1'b1;
                seq.done <= part_last;
            end else begin
                ram_we <= 1'b0;
                case (phase)
                    RD_ADDR: phase <= RD_WAIT;
                    RD_WAIT: phase <= RD_CAPTURE;
                    default: begin
                        phase    <= RD_ADDR;
                        part     <= part + 1'b1;
                        seq.done <= part_last;
                    end
                endcase
            end
        end else begin
            ram_we <= 1'b0;
            part   <= '0;
            phase  <= RD_ADDR;
            if (!seq.start) begin
                seq.done <= 1'b0;  // Drop one cycle after start falls
            end
        end
    end

    // RAM addresses and the assembled word
    always_ff @(posedge clk) begin
        if (active) begin
            if (seq.write) begin
                ram_waddr <= part_addr;
                ram_wdata <= seq.wdata[8*part +: 8];
            end else if (phase == RD_ADDR) begin
                ram_raddr <= part_addr;
                if (part == '0) begin
                    seq.rdata <= '0;
                end
            end else if (phase == RD_CAPTURE) begin
                seq.rdata <= seq.rdata | (XW'(ram_rdata) << (8 * part));  // Little-endian lane
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/lane_align.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_settings.svh"

module lane_align (
    input  mem_pkg::access_size_t  req_size,
    input  logic [`MEM_STRB-1:0]   req_wstrb,
    input  logic [`MEM_XLEN-1:0]   req_wdata,
    input  logic [`MEM_XLEN-1:0]   read_word,
    output logic [`MEM_XLEN-1:0]   rd_value,
    output logic [`MEM_XLEN-1:0]   merged_word,
    output logic                   strobe_ok
);

    localparam int SW = `MEM_STRB;

    // Legal half-word strobe patterns
    localparam logic [SW-1:0] HALF_LOW  = {{(SW-2){1'b0}}, 2'b11};
    localparam logic [SW-1:0] HALF_HIGH = {2'b11, {(SW-2){1'b0}}};

    ////////////////////////////////////////////////////////////////////////////
    // Extract, merge and strobe check per size
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        rd_value    = '0;         // Zero-extended narrow reads
        merged_word = read_word;  // Upper lanes written back as fetched
        strobe_ok   = 1'b0;

        case (req_size)
            mem_pkg::SIZE_BYTE: begin
                rd_value[7:0]    = read_word[7:0];
                merged_word[7:0] = req_wdata[7:0];
                strobe_ok        = $onehot(req_wstrb);
            end

            mem_pkg::SIZE_HALF: begin
                rd_value[15:0]    = read_word[15:0];
                merged_word[15:0] = req_wdata[15:0];
                strobe_ok         = (req_wstrb == HALF_LOW) || (req_wstrb == HALF_HIGH);
            end

            mem_pkg::SIZE_WORD: begin
                rd_value    = read_word;
                merged_word = req_wdata;
                strobe_ok   = &req_wstrb;  // Every lane
            end

            default: begin
                // Unsupported code, nothing extracted or merged
                strobe_ok = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/mem_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_settings.svh"

module mem_ctrl (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  bus_valid,
    input  logic                  bus_rw,
    input  logic [`MEM_XLEN-1:0]  bus_addr,
    input  logic [`MEM_XLEN-1:0]  bus_wdata,
    input  logic [`MEM_STRB-1:0]  bus_wstrb,
    input  logic [2:0]            bus_size,
    output logic                  bus_ready,
    output logic                  bus_denied,
    output logic [`MEM_XLEN-1:0]  bus_rdata,
    mem_seq_if.ctrl               seq,
    output mem_pkg::access_size_t req_size,
    output logic [`MEM_STRB-1:0]  req_wstrb,
    output logic [`MEM_XLEN-1:0]  req_wdata,
    output logic [`MEM_XLEN-1:0]  read_word,
    input  logic [`MEM_XLEN-1:0]  rd_value,
    input  logic [`MEM_XLEN-1:0]  merged_word,
    input  logic                  strobe_ok
);

    localparam int XW = `MEM_XLEN;
    localparam int AW = `MEM_ADDR_BITS;

    mem_pkg::mem_state_t state;

    logic [AW-1:0] req_addr;
    logic          req_read;
    logic [XW-1:0] write_word;
    logic [XW-1:0] resp_data;
    logic          resp_denied;
    logic [XW-1:0] max_addr;
    logic          size_ok;
    logic          access_denied;

    // Last legal start address per size
    always_comb begin
        size_ok = 1'b1;
        case (bus_size)
            mem_pkg::SIZE_BYTE: max_addr = XW'(`MEM_BYTES - 1);
            mem_pkg::SIZE_HALF: max_addr = XW'(`MEM_BYTES - 2);
            mem_pkg::SIZE_WORD: max_addr = XW'(`MEM_BYTES - 4);
            default: begin
                max_addr = '0;
                size_ok  = 1'b0;
            end
        endcase
    end

    assign access_denied = !size_ok || (bus_addr > max_addr);

    assign seq.write     = (state == mem_pkg::WRITE_BACK);
    assign seq.word_addr = req_addr;
    assign seq.wdata     = write_word;

    ////////////////////////////////////////////////////////////////////////////
    // Request FSM
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= mem_pkg::IDLE;
            seq.start   <= 1'b0;
            resp_denied <= 1'b0;
            bus_ready   <= 1'b0;
            bus_denied  <= 1'b0;
            bus_rdata   <= '0;
        end else begin
            case (state)
                mem_pkg::IDLE: begin
                    if (bus_valid) begin
                        resp_denied <= access_denied;
                        state       <= mem_pkg::FETCH;
                    end
                end
                mem_pkg::FETCH: begin
                    if (resp_denied) begin
                        state <= mem_pkg::RESPOND;  // Memory never touched
                    end else if (seq.done) begin
                        seq.start <= 1'b0;
                        state     <= mem_pkg::PROCESS;
                    end else begin
                        seq.start <= 1'b1;
                    end
                end
                mem_pkg::PROCESS: begin
                    if (req_read) begin
                        state <= mem_pkg::RESPOND;
                    end else if (!strobe_ok) begin
                        resp_denied <= 1'b1;  // Strobes do not fit the size
                        state       <= mem_pkg::RESPOND;
                    end else begin
                        state <= mem_pkg::WRITE_BACK;
                    end
                end
                mem_pkg::WRITE_BACK: begin
                    if (seq.done) begin
                        seq.start <= 1'b0;
                        state     <= mem_pkg::RESPOND;
                    end else begin
                        seq.start <= 1'b1;
                    end
                end
                mem_pkg::RESPOND: begin
                    bus_rdata  <= resp_data;
                    bus_denied <= resp_denied;
                    bus_ready  <= 1'b1;
                    state      <= mem_pkg::RESPOND_WAIT;
                end
                mem_pkg::RESPOND_WAIT: begin
                    // Hold the response until the master lets go
                    if (!bus_valid) begin
                        bus_ready  <= 1'b0;
                        bus_denied <= 1'b0;
                        bus_rdata  <= '0;
                        state      <= mem_pkg::IDLE;
                    end
                end
                default: state <= mem_pkg::IDLE;
            endcase
        end
    end

    // Request capture and response data
    always_ff @(posedge clk) begin
        case (state)
            mem_pkg::IDLE: begin
                if (bus_valid) begin
                    req_addr  <= bus_addr[AW-1:0];
                    req_read  <= bus_rw;
                    req_size  <= mem_pkg::access_size_t'(bus_size);
                    req_wstrb <= bus_wstrb;
                    req_wdata <= bus_wdata;
                end
            end
            mem_pkg::FETCH: begin
                resp_data <= '0;  // Left at zero for a denied request
                if (seq.done) begin
                    read_word <= seq.rdata;
                end
            end
            mem_pkg::PROCESS: begin
                resp_data  <= req_read ? rd_value : '0;
                write_word <= merged_word;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/p_memory.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_settings.svh"

module p_memory (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 bus_valid,
    input  logic                 bus_rw,      // High for read
    input  logic [`MEM_XLEN-1:0] bus_addr,
    input  logic [`MEM_XLEN-1:0] bus_wdata,
    input  logic [`MEM_STRB-1:0] bus_wstrb,
    input  logic [2:0]           bus_size,    // log2 of bytes per access
    output logic                 bus_ready,
    output logic                 bus_denied,
    output logic [`MEM_XLEN-1:0] bus_rdata
);

    mem_seq_if seq_if ();

    // Lane datapath
    mem_pkg::access_size_t      req_size;
    logic [`MEM_STRB-1:0]       req_wstrb;
    logic [`MEM_XLEN-1:0]       req_wdata;
    logic [`MEM_XLEN-1:0]       read_word;
    logic [`MEM_XLEN-1:0]       rd_value;
    logic [`MEM_XLEN-1:0]       merged_word;
    logic                       strobe_ok;

    // Block RAM port
    logic                       ram_we;
    logic [`MEM_ADDR_BITS-1:0]  ram_waddr;
    logic [`MEM_ADDR_BITS-1:0]  ram_raddr;
    logic [7:0]                 ram_wdata;
    logic [7:0]                 ram_rdata;

    ////////////////////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////////////////////
    mem_ctrl mem_ctrl_i (
        .clk         (clk),
        .reset       (reset),
        .bus_valid   (bus_valid),
        .bus_rw      (bus_rw),
        .bus_addr    (bus_addr),
        .bus_wdata   (bus_wdata),
        .bus_wstrb   (bus_wstrb),
        .bus_size    (bus_size),
        .bus_ready   (bus_ready),
        .bus_denied  (bus_denied),
        .bus_rdata   (bus_rdata),
        .seq         (seq_if.ctrl),
        .req_size    (req_size),
        .req_wstrb   (req_wstrb),
        .req_wdata   (req_wdata),
        .read_word   (read_word),
        .rd_value    (rd_value),
        .merged_word (merged_word),
        .strobe_ok   (strobe_ok)
    );

    lane_align lane_align_i (
        .req_size    (req_size),
        .req_wstrb   (req_wstrb),
        .req_wdata   (req_wdata),
        .read_word   (read_word),
        .rd_value    (rd_value),
        .merged_word (merged_word),
        .strobe_ok   (strobe_ok)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////////////////////
    mem_sequencer mem_sequencer_i (
        .clk       (clk),
        .reset     (reset),
        .seq       (seq_if.seq),
        .ram_we    (ram_we),
        .ram_waddr (ram_waddr),
        .ram_raddr (ram_raddr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    block_ram #(
        .DEPTH (`MEM_BYTES)
    ) block_ram_i (
        .clk   (clk),
        .we    (ram_we),
        .waddr (ram_waddr),
        .raddr (ram_raddr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

`default_nettype wire

//--- sim/tb_p_memory.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_settings.svh"

module tb_p_memory;

    localparam int   AW             = `MEM_ADDR_BITS;
    localparam int   RESET_CYCLES   = 10;
    localparam int   N_NARROW       = 100;
    localparam int   N_DENIED       = 37;
    localparam int   N_HANDSHAKE    = 50;
    localparam int   TOTAL_XFERS    = 2 * (`MEM_BYTES / 4) + 3 * N_NARROW + N_DENIED
                                      + 2 * N_HANDSHAKE;
    localparam int   TIMEOUT_CYCLES = TOTAL_XFERS * 40 + RESET_CYCLES;
    localparam logic READ           = 1'b1;
    localparam logic WRITE          = 1'b0;

    // Strobe patterns that break the size rules, two per size
    localparam logic [3:0] BAD_STRB [6] = '{4'b0000, 4'b0011, 4'b0110,
                                            4'b0001, 4'b0111, 4'b1110};

    logic                 clk;
    logic                 reset;
    logic                 bus_valid;
    logic                 bus_rw;
    logic [`MEM_XLEN-1:0] bus_addr;
    logic [`MEM_XLEN-1:0] bus_wdata;
    logic [`MEM_STRB-1:0] bus_wstrb;
    logic [2:0]           bus_size;
    logic                 bus_ready;
    logic                 bus_denied;
    logic [`MEM_XLEN-1:0] bus_rdata;

    logic [7:0] model_mem [`MEM_BYTES];  // Reference copy of the storage
    integer     seed = 59843;
    int         errors = 0;
    int         test_mark = 0;
    int         tests_run = 0;
    int         tests_failed = 0;

    p_memory p_memory_i (
        .clk        (clk),
        .reset      (reset),
        .bus_valid  (bus_valid),
        .bus_rw     (bus_rw),
        .bus_addr   (bus_addr),
        .bus_wdata  (bus_wdata),
        .bus_wstrb  (bus_wstrb),
        .bus_size   (bus_size),
        .bus_ready  (bus_ready),
        .bus_denied (bus_denied),
        .bus_rdata  (bus_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Handshake properties
    ////////////////////////////////////////////////////////////////////////////
    quiet_rdata_a: assert property (@(posedge clk) disable iff (reset)
        !bus_ready |-> bus_rdata == '0)
    else begin
        $display("FAILED at %0t: bus_rdata expected 0 got %h", $time, $sampled(bus_rdata));
        errors = errors + 1;
    end

    quiet_denied_a: assert property (@(posedge clk) disable iff (reset)
        !bus_ready |-> !bus_denied)
    else begin
        $display("FAILED at %0t: bus_denied expected 0 got %b", $time, $sampled(bus_denied));
        errors = errors + 1;
    end

    ready_hold_a: assert property (@(posedge clk) disable iff (reset)
        bus_ready && bus_valid |=> bus_ready)
    else begin
        $display("FAILED at %0t: bus_ready expected 1 got %b", $time, $sampled(bus_ready));
        errors = errors + 1;
    end

    ready_drop_a: assert property (@(posedge clk) disable iff (reset)
        bus_ready && !bus_valid |=> !bus_ready)
    else begin
        $display("FAILED at %0t: bus_ready expected 0 got %b", $time, $sampled(bus_ready));
        errors = errors + 1;
    end

    // No response without a request
    no_spurious_a: assert property (@(posedge clk) disable iff (reset)
        !bus_valid && !bus_ready |=> !bus_ready)
    else begin
        $display("FAILED at %0t: bus_ready expected 0 got %b", $time, $sampled(bus_ready));
        errors = errors + 1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference rules
    ////////////////////////////////////////////////////////////////////////////
    function automatic int access_bytes(input logic [2:0] size);
        case (size)
            mem_pkg::SIZE_BYTE: return 1;
            mem_pkg::SIZE_HALF: return 2;
            mem_pkg::SIZE_WORD: return 4;
            default:            return 0;  // Unsupported code
        endcase
    endfunction

    function automatic logic strobes_legal(input logic [2:0] size, input logic [3:0] strb);
        case (size)
            mem_pkg::SIZE_BYTE: return $countones(strb) == 1;
            mem_pkg::SIZE_HALF: return strb == 4'b0011 || strb == 4'b1100;
            mem_pkg::SIZE_WORD: return strb == 4'b1111;
            default:            return 1'b0;
        endcase
    endfunction

    function automatic logic [3:0] legal_strobe(input logic [2:0] size);
        return (size == mem_pkg::SIZE_BYTE) ? 4'b0001 :
               (size == mem_pkg::SIZE_HALF) ? 4'b0011 : 4'b1111;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
    endfunction

    // One four-phase transfer, response held for hold extra cycles
    task automatic bus_transfer(input logic rw, input logic [31:0] addr,
                                input logic [31:0] wdata, input logic [3:0] strb,
                                input logic [2:0] size, input int hold,
                                output logic [31:0] got_rdata, output logic got_denied);
        @(posedge clk);
        bus_valid <= 1'b1;
        bus_rw    <= rw;
        bus_addr  <= addr;
        bus_wdata <= wdata;
        bus_wstrb <= strb;
        bus_size  <= size;
        do @(posedge clk); while (!bus_ready);
        got_rdata  = bus_rdata;
        got_denied = bus_denied;
        repeat (hold) begin
            @(posedge clk);
            assert (bus_rdata == got_rdata) else begin
                $display("FAILED at %0t: bus_rdata expected %h got %h (held response)",
                         $time, got_rdata, bus_rdata);
                errors = errors + 1;
            end
            assert (bus_denied == got_denied) else begin
                $display("FAILED at %0t: bus_denied expected %b got %b (held response)",
                         $time, got_denied, bus_denied);
                errors = errors + 1;
            end
        end
        bus_valid <= 1'b0;
        do @(posedge clk); while (bus_ready);
    endtask

    task automatic checked_access(input logic rw, input logic [31:0] addr,
                                  input logic [31:0] wdata, input logic [3:0] strb,
                                  input logic [2:0] size, input int hold);
        int          n;
        int          i;
        logic [AW-1:0] idx;
        logic        exp_denied;
        logic [31:0] exp_rdata;
        logic [31:0] got_rdata;
        logic        got_denied;
        n          = access_bytes(size);
        exp_denied = (n == 0) || (addr > 32'(`MEM_BYTES - n)) ||
                     (rw == WRITE && !strobes_legal(size, strb));
        exp_rdata  = '0;
        if (!exp_denied) begin
            for (i = 0; i < n; i++) begin
                idx = AW'(addr + 32'(i));
                if (rw == READ) begin
                    exp_rdata[8*i +: 8] = model_mem[idx];
                end else begin
                    model_mem[idx] = wdata[8*i +: 8];  // Low data bytes into low lanes
                end
            end
        end
        bus_transfer(rw, addr, wdata, strb, size, hold, got_rdata, got_denied);
        assert (got_rdata == exp_rdata) else begin
            $display("FAILED at %0t: bus_rdata expected %h got %h (addr %h)",
                     $time, exp_rdata, got_rdata, addr);
            errors = errors + 1;
        end
        assert (got_denied == exp_denied) else begin
            $display("FAILED at %0t: bus_denied expected %b got %b (addr %h)",
                     $time, exp_denied, got_denied, addr);
            errors = errors + 1;
        end
    endtask

    task automatic close_test(input string name);
        tests_run = tests_run + 1;
        if (errors != test_mark) begin
            tests_failed = tests_failed + 1;
        end
        $display("Test %-14s %0d errors", name, errors - test_mark);
        test_mark = errors;
    endtask

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: no end of run after %0d cycles", TIMEOUT_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin : main_sequence
        int          k;
        int          n;
        int          hold;
        logic [31:0] r;
        logic [31:0] addr;
        logic [3:0]  strb;
        logic [2:0]  sz;
        reset     = 1'b1;
        bus_valid = 1'b0;
        bus_rw    = 1'b0;
        bus_addr  = '0;
        bus_wdata = '0;
        bus_wstrb = '0;
        bus_size  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        @(posedge clk);
        assert (!bus_ready) else begin
            $display("FAILED at %0t: bus_ready expected 0 got %b", $time, bus_ready);
            errors = errors + 1;
        end
        repeat (5) @(posedge clk);  // Idle bus, properties watch for stray ready
        close_test("reset");

        for (k = 0; k < `MEM_BYTES; k += 4) begin
            checked_access(WRITE, k, fill_word(k), 4'b1111, mem_pkg::SIZE_WORD, 0);
        end
        for (k = 0; k < `MEM_BYTES; k += 4) begin
            checked_access(READ, k, '0, 4'b0000, mem_pkg::SIZE_WORD, 0);
        end
        close_test("word_rw");

        for (k = 0; k < N_NARROW; k++) begin
            r    = $random(seed);
            sz   = r[0] ? mem_pkg::SIZE_HALF : mem_pkg::SIZE_BYTE;
            n    = access_bytes(sz);
            strb = (sz == mem_pkg::SIZE_BYTE) ? (4'b0001 << r[2:1])
                                              : (r[3] ? 4'b1100 : 4'b0011);
            r    = $random(seed);
            addr = r % (`MEM_BYTES - n + 1);
            checked_access(WRITE, addr, $random(seed), strb, sz, 0);
            checked_access(READ, (addr > `MEM_BYTES - 4) ? `MEM_BYTES - 4 : addr,
                           '0, 4'b0000, mem_pkg::SIZE_WORD, 0);
            checked_access(READ, addr, '0, 4'b0000, sz, 0);  // Zero-extended
        end
        close_test("narrow");

        // Just past the top, and far out of range
        for (k = 0; k < 3; k++) begin
            sz = 3'(k);
            n  = access_bytes(sz);
            checked_access(READ, `MEM_BYTES - n + 1, '0, 4'b0000, sz, 0);
            checked_access(WRITE, `MEM_BYTES - n + 1, $random(seed), legal_strobe(sz), sz, 0);
            checked_access(READ, 32'h0001_0000, '0, 4'b0000, sz, 0);
            checked_access(WRITE, 32'hFFFF_FFFC, $random(seed), legal_strobe(sz), sz, 0);
        end
        for (k = 0; k < 6; k++) begin
            sz   = 3'(k / 2);  // Byte, half and word in turn
            strb = BAD_STRB[k];
            r    = $random(seed);
            addr = r % (`MEM_BYTES - 3);
            checked_access(WRITE, addr, $random(seed), strb, sz, 0);
            checked_access(READ, addr, '0, 4'b0000, mem_pkg::SIZE_WORD, 0);
        end
        for (k = 3; k < 8; k++) begin
            checked_access(READ, '0, '0, 4'b0000, 3'(k), 0);
            checked_access(WRITE, '0, $random(seed), 4'b1111, 3'(k), 0);
        end
        checked_access(READ, '0, '0, 4'b0000, mem_pkg::SIZE_WORD, 0);  // Unsupported-size target
        checked_access(READ, `MEM_BYTES - 4, '0, 4'b0000, mem_pkg::SIZE_WORD, 0);
        checked_access(READ, `MEM_BYTES - 1, '0, 4'b0000, mem_pkg::SIZE_BYTE, 0);
        close_test("denied");

        for (k = 0; k < N_HANDSHAKE; k++) begin
            r    = $random(seed);
            addr = r % (`MEM_BYTES - 3);
            r    = $random(seed);
            hold = 1 + int'(r % 8);
            checked_access(WRITE, addr, $random(seed), 4'b1111, mem_pkg::SIZE_WORD, hold);
            checked_access(READ, addr, '0, 4'b0000, mem_pkg::SIZE_WORD, 1 + k % 8);
        end
        close_test("handshake");

        $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+rtl
rtl/mem_pkg.sv
rtl/mem_seq_if.sv
rtl/block_ram.sv
rtl/mem_sequencer.sv
rtl/lane_align.sv
rtl/mem_ctrl.sv
rtl/p_memory.sv
sim/tb_p_memory.sv

//--- Makefile
# Verilator build and run for the p_memory testbench

VERILATOR ?= verilator
TOP       ?= tb_p_memory
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps

SOURCES := $(wildcard rtl/*.sv rtl/*.svh sim/*.sv)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BINARY) | tee $(LOG)
	@if grep -q "^STATUS: PASS$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
